//--- verilog/cuIsaPkg.sv
/* Instruction set of the matrix-multiply control unit: opcodes and field widths,
   plus the bit positions and codes used inside the datapath control word */
package cuIsaPkg;

    localparam int insWidth    = 8;
    localparam int wEnWidth    = 16;
    localparam int incWidth    = 6;
    localparam int clrWidth    = 5;
    localparam int busWidth    = 4;
    localparam int compWidth   = 3;
    localparam int aluWidth    = 3;
    localparam int regIdxWidth = $clog2(wEnWidth);
    localparam int incIdxWidth = $clog2(incWidth);
    localparam int clrIdxWidth = $clog2(clrWidth);

    // Entry opcodes, high nibble is the instruction group
    typedef enum logic [insWidth-1:0] {
        OP_NOP    = 8'h00,
        OP_JMPM   = 8'h20, OP_JMPK   = 8'h21, OP_JMPN   = 8'h22,
        OP_COPY   = 8'h40,
        OP_LOADAR = 8'h50, OP_LOADC1 = 8'h52, OP_LOADC2 = 8'h53,
        OP_STORE  = 8'h60,
        OP_ASSIGN = 8'h70,
        OP_RSTALL = 8'h80, OP_RSTN2  = 8'h81, OP_RSTK2  = 8'h82,
        OP_MOVP   = 8'h90, OP_MOVT   = 8'h91, OP_MOVC1  = 8'h92,
        OP_SETC1  = 8'hA0, OP_SETDR  = 8'hA1,
        OP_MULP   = 8'hB0,
        OP_ADDT   = 8'hC0, OP_ADDM1  = 8'hC1, OP_ADDM2  = 8'hC2,
        OP_INCC2  = 8'hD0, OP_INCC3  = 8'hD1, OP_INCM2  = 8'hD2,
        OP_INCK2  = 8'hD3, OP_INCN2  = 8'hD4
    } opcodeE;

    // Bit of each datapath register in the write-enable word
    typedef enum logic [regIdxWidth-1:0] {
        REG_PC = 4'd15, REG_IR = 4'd14, REG_AR = 4'd13, REG_DR = 4'd12,
        REG_P  = 4'd11, REG_T  = 4'd10, REG_M1 = 4'd9,  REG_K1 = 4'd8,
        REG_N1 = 4'd7,  REG_M2 = 4'd6,  REG_K2 = 4'd5,  REG_N2 = 4'd4,
        REG_C1 = 4'd3,  REG_C2 = 4'd2,  REG_C3 = 4'd1,  REG_AC = 4'd0
    } regIdxE;

    // Bus mux source codes, gaps are the K1/N1/K2/N2 inputs that no state selects
    typedef enum logic [busWidth-1:0] {
        BUS_NONE = 4'd0,  BUS_AC = 4'd1,  BUS_C3 = 4'd2,  BUS_C2 = 4'd3,
        BUS_C1   = 4'd4,  BUS_M2 = 4'd7,  BUS_M1 = 4'd10, BUS_T  = 4'd11,
        BUS_P    = 4'd12, BUS_DR = 4'd13, BUS_AR = 4'd14
    } busSrcE;

    typedef enum logic [incIdxWidth-1:0] {
        INC_PC = 3'd5, INC_M2 = 3'd4, INC_K2 = 3'd3,
        INC_N2 = 3'd2, INC_C2 = 3'd1, INC_C3 = 3'd0
    } incBitE;

    typedef enum logic [clrIdxWidth-1:0] {
        CLR_T = 3'd4, CLR_M2 = 3'd3, CLR_K2 = 3'd2, CLR_N2 = 3'd1, CLR_AC = 3'd0
    } clrBitE;

    // Comparator pair select, one-hot, drives both muxes
    typedef enum logic [compWidth-1:0] {
        CMP_NONE = 3'b000, CMP_NN = 3'b001, CMP_KK = 3'b010, CMP_MM = 3'b100
    } compSelE;

    typedef enum logic [aluWidth-1:0] {
        ALU_NONE = 3'b000, ALU_SET = 3'b001, ALU_MUL = 3'b010, ALU_ADD = 3'b100
    } aluOpE;

endpackage

//--- verilog/cuStatePkg.sv
/* Sequencer states and the helpers that pick entry and sub-target states.
   Entry states carry the value of their opcode so dispatch is a plain cast */
package cuStatePkg;
    import cuIsaPkg::*;

    typedef enum logic [insWidth-1:0] {
        ST_IDLE = 8'h00,
        ST_FETCH1 = 8'h10, ST_FETCH2 = 8'h11, ST_FETCH3 = 8'h12,
        ST_JMPM = OP_JMPM, ST_JMPK = OP_JMPK, ST_JMPN = OP_JMPN,
        ST_JUMPREAD = 8'h24, ST_JUMPLOADAR = 8'h25, ST_JUMPLOADPC = 8'h26,
        ST_SKIP = 8'h30,
        ST_COPY = OP_COPY,
        ST_COPYLOADAR = 8'h41, ST_COPYREAD = 8'h42, ST_COPYLOADDR = 8'h43,
        ST_COPYM1 = 8'h44, ST_COPYK1 = 8'h45, ST_COPYN1 = 8'h46,
        ST_LOADAR = OP_LOADAR, ST_LOADDR = 8'h51,
        ST_LOADC1 = OP_LOADC1, ST_LOADC2 = OP_LOADC2,
        ST_STORE = OP_STORE, ST_STOREAR = 8'h61, ST_STOREWRITE = 8'h62,
        ST_ASSIGN = OP_ASSIGN, ST_ASSIGNLOADAR = 8'h71,
        ST_ASSIGNC1 = 8'h72, ST_ASSIGNC2 = 8'h73, ST_ASSIGNC3 = 8'h74,
        ST_RSTALL = OP_RSTALL, ST_RSTN2 = OP_RSTN2, ST_RSTK2 = OP_RSTK2,
        ST_MOVP = OP_MOVP, ST_MOVT = OP_MOVT, ST_MOVC1 = OP_MOVC1,
        ST_SETC1 = OP_SETC1, ST_SETDR = OP_SETDR,
        ST_MULP = OP_MULP,
        ST_ADDT = OP_ADDT, ST_ADDM1 = OP_ADDM1, ST_ADDM2 = OP_ADDM2,
        ST_INCC2 = OP_INCC2, ST_INCC3 = OP_INCC3, ST_INCM2 = OP_INCM2,
        ST_INCK2 = OP_INCK2, ST_INCN2 = OP_INCN2
    } cuStateE;

    // NOP and every unlisted value fall back to fetch
    function automatic logic isEntry(input logic [insWidth-1:0] ins);
        case (ins)
            OP_JMPM, OP_JMPK, OP_JMPN, OP_COPY,
            OP_LOADAR, OP_LOADC1, OP_LOADC2, OP_STORE, OP_ASSIGN,
            OP_RSTALL, OP_RSTN2, OP_RSTK2, OP_MOVP, OP_MOVT, OP_MOVC1,
            OP_SETC1, OP_SETDR, OP_MULP, OP_ADDT, OP_ADDM1, OP_ADDM2,
            OP_INCC2, OP_INCC3, OP_INCM2, OP_INCK2, OP_INCN2: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Low instruction bits pick M1, K1 or N1
    function automatic cuStateE copyTarget(input logic [1:0] sel);
        case (sel)
            2'd0:    return ST_COPYM1;
            2'd1:    return ST_COPYK1;
            2'd2:    return ST_COPYN1;
            default: return ST_FETCH1;
        endcase
    endfunction

    // Low instruction bits pick C1, C2 or C3
    function automatic cuStateE assignTarget(input logic [1:0] sel);
        case (sel)
            2'd0:    return ST_ASSIGNC1;
            2'd1:    return ST_ASSIGNC2;
            2'd2:    return ST_ASSIGNC3;
            default: return ST_FETCH1;
        endcase
    endfunction

endpackage

//--- verilog/ctrlBusIf.sv
/* Datapath control word, driven by the microcode table and read by the top level */
interface ctrlBusIf import cuIsaPkg::*; ();
    logic                 insRead;   // Instruction memory read
    logic                 memRead;   // Data memory read
    logic                 memWrite;
    logic [wEnWidth-1:0]  wEn;       // One bit per datapath register
    busSrcE               busSel;
    logic [incWidth-1:0]  inc;
    logic [clrWidth-1:0]  regClr;    // Synchronous clears in the datapath
    compSelE              compSel;
    aluOpE                aluOp;

    modport microcode (
        output insRead, memRead, memWrite,
        output wEn, busSel, inc, regClr,
        output compSel, aluOp
    );

    modport sink (
        input insRead, memRead, memWrite,
        input wEn, busSel, inc, regClr,
        input compSel, aluOp
    );

endinterface

//--- verilog/cuSequencer.sv
/* State register and next-state logic of the control unit. Every state lasts one
   clock; the opcode is taken from ir at the end of FETCH3 and kept for sub-selects */
module cuSequencer import cuIsaPkg::*; import cuStatePkg::*; (
    input  logic                Clk,
    input  logic                rstN,
    input  logic                z,        // Comparator zero flag
    input  logic [insWidth-1:0] ir,       // Instruction register from the datapath
    output cuStateE             nextState
);

    cuStateE    state;
    logic [1:0] insSel;                   // Target bits of the running instruction

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Target bits of COPY and ASSIGN, taken at the end of FETCH3
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            insSel <= '0;
        end else if (state == ST_FETCH3) begin
            insSel <= ir[1:0];
        end
    end

    always_comb begin
        nextState = ST_FETCH1;            // Last states and undefined codes
        case (state)
            ST_IDLE:   nextState = ST_FETCH1;
            ST_FETCH1: nextState = ST_FETCH2;
            ST_FETCH2: nextState = ST_FETCH3;
            ST_FETCH3: begin
                // COPY and ASSIGN carry their target in the low two bits
                if ((ir >> 2) == (OP_COPY >> 2)) begin
                    nextState = ST_COPY;
                end else if ((ir >> 2) == (OP_ASSIGN >> 2)) begin
                    nextState = ST_ASSIGN;
                end else if (isEntry(ir)) begin
                    nextState = cuStateE'(ir);
                end else begin
                    nextState = ST_FETCH1;
                end
            end

            // z high means the compared pair differs, so skip the target word
            ST_JMPM, ST_JMPK, ST_JMPN: begin
                nextState = z ? ST_SKIP : ST_JUMPREAD;
            end
            ST_JUMPREAD:   nextState = ST_JUMPLOADAR;
            ST_JUMPLOADAR: nextState = ST_JUMPLOADPC;

            ST_COPY:       nextState = ST_COPYLOADAR;
            ST_COPYLOADAR: nextState = ST_COPYREAD;
            ST_COPYREAD:   nextState = ST_COPYLOADDR;
            ST_COPYLOADDR: nextState = copyTarget(insSel);

            ST_LOADC1, ST_LOADC2: nextState = ST_LOADAR;   // Address set, then plain load
            ST_LOADAR:            nextState = ST_LOADDR;

            ST_STORE:   nextState = ST_STOREAR;
            ST_STOREAR: nextState = ST_STOREWRITE;

            ST_ASSIGN:       nextState = ST_ASSIGNLOADAR;
            ST_ASSIGNLOADAR: nextState = assignTarget(insSel);

            default: nextState = ST_FETCH1;
        endcase
    end

endmodule

//--- verilog/cuMicrocode.sv
/* Microcode table: decodes the sequencer's next state into the datapath control word
   and registers it, so the outputs line up with the state the sequencer holds */
module cuMicrocode import cuIsaPkg::*; import cuStatePkg::*; (
    input  logic       Clk,
    input  logic       rstN,
    input  cuStateE    nextState,
    ctrlBusIf.microcode ctrlBus
);

    logic                insReadNxt;
    logic                memReadNxt;
    logic                memWriteNxt;
    logic [wEnWidth-1:0] wEnNxt;
    busSrcE              busSelNxt;
    logic [incWidth-1:0] incNxt;
    logic [clrWidth-1:0] regClrNxt;
    compSelE             compSelNxt;
    aluOpE               aluOpNxt;

    always_comb begin
        insReadNxt  = 1'b0;
        memReadNxt  = 1'b0;
        memWriteNxt = 1'b0;
        wEnNxt      = '0;
        busSelNxt   = BUS_NONE;
        incNxt      = '0;
        regClrNxt   = '0;
        compSelNxt  = CMP_NONE;
        aluOpNxt    = ALU_NONE;

        case (nextState)
            // Fetch and the operand-word reads share the instruction strobe
            ST_FETCH1, ST_JUMPREAD, ST_COPY, ST_ASSIGN: insReadNxt = 1'b1;
            ST_FETCH2: begin
                wEnNxt[REG_IR] = 1'b1;
                incNxt[INC_PC] = 1'b1;
            end
            ST_FETCH3, ST_SKIP: incNxt[INC_PC] = 1'b1;

            ST_JMPM: compSelNxt = CMP_MM;
            ST_JMPK: compSelNxt = CMP_KK;
            ST_JMPN: compSelNxt = CMP_NN;
            ST_JUMPLOADAR: wEnNxt[REG_AR] = 1'b1;
            ST_JUMPLOADPC: begin
                wEnNxt[REG_PC] = 1'b1;
                busSelNxt      = BUS_AR;
            end

            // AR takes the operand word, PC moves past it
            ST_COPYLOADAR, ST_ASSIGNLOADAR: begin
                wEnNxt[REG_AR] = 1'b1;
                incNxt[INC_PC] = 1'b1;
            end
            ST_COPYREAD, ST_LOADAR:  memReadNxt = 1'b1;
            ST_COPYLOADDR, ST_LOADDR: wEnNxt[REG_DR] = 1'b1;
            ST_COPYM1: begin
                wEnNxt[REG_M1] = 1'b1;
                busSelNxt      = BUS_DR;
            end
            ST_COPYK1: begin
                wEnNxt[REG_K1] = 1'b1;
                busSelNxt      = BUS_DR;
            end
            ST_COPYN1: begin
                wEnNxt[REG_N1] = 1'b1;
                busSelNxt      = BUS_DR;
            end

            ST_LOADC1: begin
                wEnNxt[REG_AR] = 1'b1;
                busSelNxt      = BUS_C1;
            end
            ST_LOADC2: begin
                wEnNxt[REG_AR] = 1'b1;
                busSelNxt      = BUS_C2;
            end

            ST_STORE: begin
                wEnNxt[REG_DR] = 1'b1;
                busSelNxt      = BUS_T;
            end
            ST_STOREAR: begin
                wEnNxt[REG_AR] = 1'b1;
                busSelNxt      = BUS_C3;
            end
            ST_STOREWRITE: memWriteNxt = 1'b1;

            ST_ASSIGNC1: begin
                wEnNxt[REG_C1] = 1'b1;
                busSelNxt      = BUS_AR;
            end
            ST_ASSIGNC2: begin
                wEnNxt[REG_C2] = 1'b1;
                busSelNxt      = BUS_AR;
            end
            ST_ASSIGNC3: begin
                wEnNxt[REG_C3] = 1'b1;
                busSelNxt      = BUS_AR;
            end

            ST_RSTALL: regClrNxt = '1;            // T, M2, K2, N2 and AC
            ST_RSTN2:  regClrNxt[CLR_N2] = 1'b1;
            ST_RSTK2:  regClrNxt[CLR_K2] = 1'b1;

            ST_MOVP: begin
                wEnNxt[REG_P] = 1'b1;
                busSelNxt     = BUS_AC;
            end
            ST_MOVT: begin
                wEnNxt[REG_T] = 1'b1;
                busSelNxt     = BUS_AC;
            end
            ST_MOVC1: begin
                wEnNxt[REG_C1] = 1'b1;
                busSelNxt      = BUS_AC;
            end

            // ALU results always land in AC
            ST_SETC1, ST_SETDR: begin
                wEnNxt[REG_AC] = 1'b1;
                aluOpNxt       = ALU_SET;
                busSelNxt      = (nextState == ST_SETC1) ? BUS_C1 : BUS_DR;
            end
            ST_MULP: begin
                wEnNxt[REG_AC] = 1'b1;
                aluOpNxt       = ALU_MUL;
                busSelNxt      = BUS_P;
            end
            ST_ADDT, ST_ADDM1, ST_ADDM2: begin
                wEnNxt[REG_AC] = 1'b1;
                aluOpNxt       = ALU_ADD;
                case (nextState)
                    ST_ADDT:  busSelNxt = BUS_T;
                    ST_ADDM1: busSelNxt = BUS_M1;
                    default:  busSelNxt = BUS_M2;
                endcase
            end

            ST_INCC2: incNxt[INC_C2] = 1'b1;
            ST_INCC3: incNxt[INC_C3] = 1'b1;
            ST_INCM2: incNxt[INC_M2] = 1'b1;
            ST_INCK2: incNxt[INC_K2] = 1'b1;
            ST_INCN2: incNxt[INC_N2] = 1'b1;

            default: ;                            // IDLE and unused codes stay all zero
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ctrlBus.insRead  <= 1'b0;
            ctrlBus.memRead  <= 1'b0;
            ctrlBus.memWrite <= 1'b0;
            ctrlBus.wEn      <= '0;
            ctrlBus.busSel   <= BUS_NONE;
            ctrlBus.inc      <= '0;
            ctrlBus.regClr   <= '0;
            ctrlBus.compSel  <= CMP_NONE;
            ctrlBus.aluOp    <= ALU_NONE;
        end else begin
            ctrlBus.insRead  <= insReadNxt;
            ctrlBus.memRead  <= memReadNxt;
            ctrlBus.memWrite <= memWriteNxt;
            ctrlBus.wEn      <= wEnNxt;
            ctrlBus.busSel   <= busSelNxt;
            ctrlBus.inc      <= incNxt;
            ctrlBus.regClr   <= regClrNxt;
            ctrlBus.compSel  <= compSelNxt;
            ctrlBus.aluOp    <= aluOpNxt;
        end
    end

endmodule

//--- verilog/cuTop.sv
/* Control unit top level: sequencer plus microcode table, with the control word
   brought out on plain ports for the datapath and the two memories */
module cuTop import cuIsaPkg::*; import cuStatePkg::*; (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 z,
    input  logic [insWidth-1:0]  ir,
    output logic                 insRead,
    output logic                 memRead,
    output logic                 memWrite,
    output logic [wEnWidth-1:0]  wEn,
    output logic [busWidth-1:0]  busSel,
    output logic [incWidth-1:0]  inc,
    output logic [clrWidth-1:0]  regClr,
    output logic [compWidth-1:0] compSel,
    output logic [aluWidth-1:0]  aluOp
);

    cuStateE nextState;

    ctrlBusIf ctrlBus ();

    cuSequencer uSequencer (
        .Clk       (Clk),
        .rstN      (rstN),
        .z         (z),
        .ir        (ir),
        .nextState (nextState)
    );

    // Registers the word of nextState, so outputs match the held state
    cuMicrocode uMicrocode (
        .Clk       (Clk),
        .rstN      (rstN),
        .nextState (nextState),
        .ctrlBus   (ctrlBus.microcode)
    );

    assign insRead  = ctrlBus.insRead;
    assign memRead  = ctrlBus.memRead;
    assign memWrite = ctrlBus.memWrite;
    assign wEn      = ctrlBus.wEn;
    assign busSel   = ctrlBus.busSel;
    assign inc      = ctrlBus.inc;
    assign regClr   = ctrlBus.regClr;
    assign compSel  = ctrlBus.compSel;
    assign aluOp    = ctrlBus.aluOp;

endmodule

//--- tests/cuChecker.sv
/* Watches the control unit ports, runs its own model of the sequencer and
   compares the whole control word at every falling clock edge */
module cuChecker (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        z,
    input  logic [7:0]  ir,
    input  logic        insRead,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [15:0] wEn,
    input  logic [3:0]  busSel,
    input  logic [5:0]  inc,
    input  logic [4:0]  regClr,
    input  logic [2:0]  compSel,
    input  logic [2:0]  aluOp,
    output int          errCount,
    output int          checkCount
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]  modelState = 8'h00;
    logic [1:0]  modelSel = 2'd0;      // Latched target bits for sub-selects
    logic [39:0] expWord;
    logic [39:0] gotWord;

    initial begin
        errCount = 0;
        checkCount = 0;
    end

    function automatic logic knownOpcode(input logic [7:0] v);
        case (v)
            8'h20, 8'h21, 8'h22, 8'h40, 8'h50, 8'h52, 8'h53, 8'h60, 8'h70,
            8'h80, 8'h81, 8'h82, 8'h90, 8'h91, 8'h92, 8'hA0, 8'hA1, 8'hB0,
            8'hC0, 8'hC1, 8'hC2, 8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hD4: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // COPY and ASSIGN keep their target in the low two bits
    function automatic logic [7:0] dispatchState(input logic [7:0] v);
        if (v[7:2] == 6'h10) begin
            return 8'h40;
        end else if (v[7:2] == 6'h1C) begin
            return 8'h70;
        end else if (knownOpcode(v)) begin
            return v;
        end else begin
            return 8'h10;
        end
    endfunction

    function automatic logic [7:0] refNext(input logic [7:0] st, input logic [7:0] ins,
                                           input logic zv, input logic [1:0] sel);
        case (st)
            8'h10: return 8'h11;
            8'h11: return 8'h12;
            8'h12: return dispatchState(ins);
            8'h20, 8'h21, 8'h22: return zv ? 8'h30 : 8'h24;
            8'h24: return 8'h25;
            8'h25: return 8'h26;
            8'h40: return 8'h41;
            8'h41: return 8'h42;
            8'h42: return 8'h43;
            8'h43: return (sel == 2'd3) ? 8'h10 : 8'h44 + 8'(sel);
            8'h50: return 8'h51;
            8'h52, 8'h53: return 8'h50;    // Address first, then the load
            8'h60: return 8'h61;
            8'h61: return 8'h62;
            8'h70: return 8'h71;
            8'h71: return (sel == 2'd3) ? 8'h10 : 8'h72 + 8'(sel);
            default: return 8'h10;         // IDLE and every last state
        endcase
    endfunction

    // Packed as insRead, memRead, memWrite, wEn, busSel, inc, regClr, compSel, aluOp
    function automatic logic [39:0] refWord(input logic [7:0] st);
        logic        ins;
        logic        mr;
        logic        mw;
        logic [15:0] w;
        logic [3:0]  b;
        logic [5:0]  i;
        logic [4:0]  c;
        logic [2:0]  cs;
        logic [2:0]  al;
        {ins, mr, mw, w, b, i, c, cs, al} = '0;
        ins = (st == 8'h10 || st == 8'h24 || st == 8'h40 || st == 8'h70);
        mr = (st == 8'h42 || st == 8'h50);
        mw = (st == 8'h62);
        // Write enables, PC at bit 15 down to AC at bit 0
        case (st)
            8'h26: w[15] = 1'b1;
            8'h11: w[14] = 1'b1;
            8'h25, 8'h41, 8'h52, 8'h53, 8'h61, 8'h71: w[13] = 1'b1;
            8'h43, 8'h51, 8'h60: w[12] = 1'b1;
            8'h90: w[11] = 1'b1;
            8'h91: w[10] = 1'b1;
            8'h44: w[9] = 1'b1;
            8'h45: w[8] = 1'b1;
            8'h46: w[7] = 1'b1;
            8'h72, 8'h92: w[3] = 1'b1;
            8'h73: w[2] = 1'b1;
            8'h74: w[1] = 1'b1;
            8'hA0, 8'hA1, 8'hB0, 8'hC0, 8'hC1, 8'hC2: w[0] = 1'b1;
            default: ;
        endcase
        case (st)
            8'h26, 8'h72, 8'h73, 8'h74: b = 4'd14;     // AR
            8'h44, 8'h45, 8'h46, 8'hA1: b = 4'd13;     // DR
            8'hB0:                      b = 4'd12;
            8'h60, 8'hC0:               b = 4'd11;     // T
            8'hC1:                      b = 4'd10;
            8'hC2:                      b = 4'd7;
            8'h52, 8'hA0:               b = 4'd4;      // C1
            8'h53:                      b = 4'd3;
            8'h61:                      b = 4'd2;
            8'h90, 8'h91, 8'h92:        b = 4'd1;      // AC
            default: ;
        endcase
        case (st)
            8'h11, 8'h12, 8'h30, 8'h41, 8'h71: i[5] = 1'b1;   // PC steps
            8'hD2: i[4] = 1'b1;
            8'hD3: i[3] = 1'b1;
            8'hD4: i[2] = 1'b1;
            8'hD0: i[1] = 1'b1;
            8'hD1: i[0] = 1'b1;
            default: ;
        endcase
        case (st)
            8'h80:   c = 5'b11111;
            8'h81:   c[1] = 1'b1;
            8'h82:   c[2] = 1'b1;
            default: ;
        endcase
        case (st)
            8'h20:   cs = 3'b100;
            8'h21:   cs = 3'b010;
            8'h22:   cs = 3'b001;
            default: ;
        endcase
        case (st)
            8'hA0, 8'hA1:        al = 3'b001;
            8'hB0:               al = 3'b010;
            8'hC0, 8'hC1, 8'hC2: al = 3'b100;
            default: ;
        endcase
        return {ins, mr, mw, w, b, i, c, cs, al};
    endfunction

    task automatic compareField(input string name, input logic [15:0] expV,
                                input logic [15:0] gotV);
        checkCount++;
        if (gotV !== expV) begin
            errCount++;
            $display("error at %0t ns: state %h field %s expected %h got %h",
                     $time, modelState, name, expV, gotV);
        end
    endtask

    // Outputs are stable at the falling edge, inputs already set for the next rise
    always @(negedge Clk) begin
        if (!rstN) begin
            modelState = 8'h00;
        end
        expWord = refWord(modelState);
        gotWord = {insRead, memRead, memWrite, wEn, busSel, inc, regClr, compSel, aluOp};
        compareField("insRead", 16'(expWord[39]), 16'(gotWord[39]));
        compareField("memRead", 16'(expWord[38]), 16'(gotWord[38]));
        compareField("memWrite", 16'(expWord[37]), 16'(gotWord[37]));
        compareField("wEn", expWord[36:21], gotWord[36:21]);
        compareField("busSel", 16'(expWord[20:17]), 16'(gotWord[20:17]));
        compareField("inc", 16'(expWord[16:11]), 16'(gotWord[16:11]));
        compareField("regClr", 16'(expWord[10:6]), 16'(gotWord[10:6]));
        compareField("compSel", 16'(expWord[5:3]), 16'(gotWord[5:3]));
        compareField("aluOp", 16'(expWord[2:0]), 16'(gotWord[2:0]));
        if (rstN) begin
            if (modelState == 8'h12) begin
                modelSel = ir[1:0];
            end
            modelState = refNext(modelState, ir, z, modelSel);
        end
    end

endmodule

//--- tests/cuTb.sv
/* Testbench top for the control unit: clock, reset, instruction programs and
   watchdog. cuChecker does all comparing; this module reports the totals */
module cuTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numInstr  = 240;    // Upper bound on instructions issued
    localparam int waitLimit = 20;     // Cycles allowed between two fetches

    logic        Clk = 1'b0;
    logic        rstN;
    logic        z;
    logic [7:0]  ir;
    logic        insRead, memRead, memWrite;
    logic [15:0] wEn;
    logic [3:0]  busSel;
    logic [5:0]  inc;
    logic [4:0]  regClr;
    logic [2:0]  compSel, aluOp;
    int          errCount, checkCount;
    int          testCount = 0;
    int          failedTests = 0;
    int          lastErrors = 0;
    bit          hung = 1'b0;
    logic [31:0] lcgState = 32'd71;

    always #5 Clk = ~Clk;

    cuTop u_dut (
        .Clk(Clk), .rstN(rstN), .z(z), .ir(ir),
        .insRead(insRead), .memRead(memRead), .memWrite(memWrite),
        .wEn(wEn), .busSel(busSel), .inc(inc), .regClr(regClr),
        .compSel(compSel), .aluOp(aluOp)
    );

    cuChecker uChecker (
        .Clk(Clk), .rstN(rstN), .z(z), .ir(ir),
        .insRead(insRead), .memRead(memRead), .memWrite(memWrite),
        .wEn(wEn), .busSel(busSel), .inc(inc), .regClr(regClr),
        .compSel(compSel), .aluOp(aluOp),
        .errCount(errCount), .checkCount(checkCount)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // FETCH2 is the only word that writes IR, so it marks each new fetch
    task automatic waitFetch();
        int n;
        n = 0;
        do begin
            @(posedge Clk);
            n++;
        end while (!wEn[14] && n < waitLimit);
        if (!wEn[14]) begin
            hung = 1'b1;
            $display("no instruction fetch seen within %0d cycles", waitLimit);
        end
    endtask

    // Drives the opcode during FETCH3 and holds it with z through execution
    task automatic runInstr(input logic [7:0] op, input logic zv);
        waitFetch();
        ir <= op;
        z  <= zv;
    endtask

    task automatic finishTest(input string name);
        waitFetch();                   // Lets the last instruction complete
        testCount++;
        if (errCount != lastErrors || hung) begin
            failedTests++;
        end
        $display("test %s done, %0d errors", name, errCount - lastErrors);
        lastErrors = errCount;
    endtask

    initial begin
        #((numInstr * 8 + 100) * 10);
        $display("watchdog expired, the control unit stopped making progress");
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [7:0] singleOps [17];
        logic [7:0] memOps [4];
        singleOps = '{8'h80, 8'h81, 8'h82, 8'h90, 8'h91, 8'h92, 8'hA0, 8'hA1, 8'hB0,
                      8'hC0, 8'hC1, 8'hC2, 8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hD4};
        memOps = '{8'h50, 8'h52, 8'h53, 8'h60};
        rstN = 1'b0;
        z = 1'b0;
        ir = 8'h00;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        finishTest("reset");

        foreach (singleOps[k]) runInstr(singleOps[k], 1'b0);
        finishTest("single-cycle");

        for (int k = 0; k < 3; k++) begin
            runInstr(8'h20 + 8'(k), 1'b1);  // Skip path
            runInstr(8'h20 + 8'(k), 1'b0);  // Taken path
        end
        finishTest("jumps");

        for (int k = 0; k < 4; k++) begin
            runInstr(8'h40 | 8'(k), 1'b0);
            runInstr(8'h70 | 8'(k), 1'b0);
        end
        foreach (memOps[k]) runInstr(memOps[k], 1'b0);
        finishTest("memory");

        for (int k = 0; k < 200; k++) begin
            lcgState = lcgNext(lcgState);
            runInstr(lcgState[23:16], lcgState[28]);
        end
        finishTest("random");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errCount);
        if (failedTests == 0 && errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/cuIsaPkg.sv
verilog/cuStatePkg.sv
verilog/ctrlBusIf.sv
verilog/cuSequencer.sv
verilog/cuMicrocode.sv
verilog/cuTop.sv
tests/cuChecker.sv
tests/cuTb.sv

//--- build.sh
#!/bin/sh
# Compiles the control unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -f project.f --top-module cuTb -o cuSim
status=$?
if [ $status -ne 0 ]; then
    echo "compile step failed with status $status"
    exit 1
fi

./obj_dir/cuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
